/* issue_pkg.sv */
// shared opcode and exception types plus opcode helpers for the dual-issue core modules
package issue_pkg;

    parameter int REG_W = 5;
    parameter int XLEN = 32;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_ADDI,
        OP_MUL
    } opcode_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_INE,
        EXC_SYS
    } exc_e;

    // single-cycle ops that either unit may run
    function automatic logic is_alu_op(opcode_e op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_ADDI: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // a slot with nothing to execute and nothing to report
    function automatic logic is_empty(opcode_e op, exc_e exc);
        return op == OP_NOP && exc == EXC_NONE;
    endfunction

    // common datapath of both units
    function automatic logic [XLEN-1:0] alu_calc(opcode_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b, logic [XLEN-1:0] imm);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_ADDI: return a + imm;
            default: return '0;
        endcase
    endfunction

endpackage

/* uop_if.sv */
`timescale 1ns/1ps
// one issued micro-op as carried from the issue stage to an execute unit
interface uop_if #(
    parameter int xlen = issue_pkg::XLEN
) ();

    logic                          en;
    issue_pkg::opcode_e            op;
    logic [issue_pkg::REG_W-1:0]   rd;
    logic [issue_pkg::REG_W-1:0]   rj;
    logic [issue_pkg::REG_W-1:0]   rk;
    logic [xlen-1:0]               imm;
    logic [xlen-1:0]               pc;
    issue_pkg::exc_e               exc;

    modport issue (
        output en, op, rd, rj, rk, imm, pc, exc
    );

    modport exec (
        input en, op, rd, rj, rk, imm, pc, exc
    );

endinterface

/* issue_stage.sv */
`timescale 1ns/1ps
// two-slot in-order issue buffer that compacts incoming pairs and dispatches to both units
module issue_stage #(
    parameter int xlen = issue_pkg::XLEN
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  issue_pkg::opcode_e          in0_op,
    input  logic [issue_pkg::REG_W-1:0] in0_rd,
    input  logic [issue_pkg::REG_W-1:0] in0_rj,
    input  logic [issue_pkg::REG_W-1:0] in0_rk,
    input  logic [xlen-1:0]             in0_imm,
    input  logic [xlen-1:0]             in0_pc,
    input  issue_pkg::exc_e             in0_exc,
    input  issue_pkg::opcode_e          in1_op,
    input  logic [issue_pkg::REG_W-1:0] in1_rd,
    input  logic [issue_pkg::REG_W-1:0] in1_rj,
    input  logic [issue_pkg::REG_W-1:0] in1_rk,
    input  logic [xlen-1:0]             in1_imm,
    input  logic [xlen-1:0]             in1_pc,
    input  issue_pkg::exc_e             in1_exc,
    output logic [1:0]                  num_read,
    input  logic                        eu0_ready,
    uop_if.issue                        eu0_bus,
    uop_if.issue                        eu1_bus
);

    typedef struct packed {
        issue_pkg::opcode_e          op;
        logic [issue_pkg::REG_W-1:0] rd;
        logic [issue_pkg::REG_W-1:0] rj;
        logic [issue_pkg::REG_W-1:0] rk;
        logic [xlen-1:0]             imm;
        logic [xlen-1:0]             pc;
        issue_pkg::exc_e             exc;
    } slot_t;

    slot_t      slot0;
    slot_t      slot1;
    slot_t      in0;
    slot_t      in1;
    slot_t      in_a;
    logic [1:0] fill;
    logic [1:0] size_after;
    logic [1:0] n_in;
    logic       in0_empty;
    logic       in1_empty;
    logic       raw_hazard;
    logic       eu0_en;
    logic       eu1_en;

    assign in0 = '{op: in0_op, rd: in0_rd, rj: in0_rj, rk: in0_rk,
                   imm: in0_imm, pc: in0_pc, exc: in0_exc};
    assign in1 = '{op: in1_op, rd: in1_rd, rj: in1_rj, rk: in1_rk,
                   imm: in1_imm, pc: in1_pc, exc: in1_exc};

    assign in0_empty = issue_pkg::is_empty(in0_op, in0_exc);
    assign in1_empty = issue_pkg::is_empty(in1_op, in1_exc);

    // squeeze out an empty first input
    assign in_a = in0_empty ? in1 : in0;
    assign n_in = 2'(!in0_empty) + 2'(!in1_empty);

    // slot 1 may not read the register slot 0 writes
    assign raw_hazard = slot0.rd != '0 && (slot1.rj == slot0.rd || slot1.rk == slot0.rd);

    assign eu0_en = !flush && eu0_ready && fill != 2'd0;
    assign eu1_en = eu0_en && fill == 2'd2 && issue_pkg::is_alu_op(slot1.op)
                    && slot1.exc == issue_pkg::EXC_NONE
                    && slot0.op != issue_pkg::OP_MUL && !raw_hazard;

    // slots still occupied once this cycle's issue leaves
    assign size_after = fill - 2'(eu0_en) - 2'(eu1_en);

    always_comb begin
        if (flush || size_after == 2'd2) begin
            num_read = 2'b00;
        end else if (size_after == 2'd1) begin
            num_read = 2'b01;
        end else begin
            num_read = 2'b11;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill <= 2'd0;
        end else if (flush) begin
            fill <= 2'd0;
        end else begin
            case (size_after)
                2'd0:    fill <= n_in;
                2'd1:    fill <= 2'd1 + 2'(!in0_empty);
                default: fill <= size_after;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (size_after)
            2'd0: begin
                slot0 <= in_a;
                slot1 <= in1;
            end
            2'd1: begin
                // survivor moves to the front and one input refills behind it
                if (fill == 2'd2) begin
                    slot0 <= slot1;
                end
                slot1 <= in0;
            end
            default: ;
        endcase
    end

    assign eu0_bus.en  = eu0_en;
    assign eu0_bus.op  = slot0.op;
    assign eu0_bus.rd  = slot0.rd;
    assign eu0_bus.rj  = slot0.rj;
    assign eu0_bus.rk  = slot0.rk;
    assign eu0_bus.imm = slot0.imm;
    assign eu0_bus.pc  = slot0.pc;
    assign eu0_bus.exc = slot0.exc;

    assign eu1_bus.en  = eu1_en;
    assign eu1_bus.op  = slot1.op;
    assign eu1_bus.rd  = slot1.rd;
    assign eu1_bus.rj  = slot1.rj;
    assign eu1_bus.rk  = slot1.rk;
    assign eu1_bus.imm = slot1.imm;
    assign eu1_bus.pc  = slot1.pc;
    assign eu1_bus.exc = slot1.exc;

    // the buffer never holds more than its two slots
    a_fill_range: assert property (@(posedge clk) disable iff (!arst_n)
        fill != 2'd3);

endmodule

/* alu_unit.sv */
`timescale 1ns/1ps
// execute unit 1 running single-cycle ALU ops with a registered writeback
module alu_unit #(
    parameter int xlen = issue_pkg::XLEN
) (
    input  logic                        clk,
    input  logic                        arst_n,
    uop_if.exec                         bus,
    input  logic [xlen-1:0]             rj_val,
    input  logic [xlen-1:0]             rk_val,
    output logic                        wb_valid,
    output logic [issue_pkg::REG_W-1:0] wb_rd,
    output logic [xlen-1:0]             wb_data,
    output logic [issue_pkg::REG_W-1:0] rj_idx,
    output logic [issue_pkg::REG_W-1:0] rk_idx
);

    // operands come back from the register file in the issue cycle
    assign rj_idx = bus.rj;
    assign rk_idx = bus.rk;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= bus.en;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.en) begin
            wb_rd   <= bus.rd;
            wb_data <= issue_pkg::alu_calc(bus.op, rj_val, rk_val, bus.imm);
        end
    end

    a_alu_only: assert property (@(posedge clk) disable iff (!arst_n)
        bus.en |-> issue_pkg::is_alu_op(bus.op));

endmodule

/* mul_alu_unit.sv */
`timescale 1ns/1ps
// execute unit 0 with ALU ops, an iterative shift-add multiply and exception reporting
module mul_alu_unit #(
    parameter int xlen = issue_pkg::XLEN
) (
    input  logic                        clk,
    input  logic                        arst_n,
    uop_if.exec                         bus,
    input  logic [xlen-1:0]             rj_val,
    input  logic [xlen-1:0]             rk_val,
    output logic                        wb_valid,
    output logic [issue_pkg::REG_W-1:0] wb_rd,
    output logic [xlen-1:0]             wb_data,
    output logic [issue_pkg::REG_W-1:0] rj_idx,
    output logic [issue_pkg::REG_W-1:0] rk_idx,
    output logic                        ready,
    output logic                        exc_valid,
    output issue_pkg::exc_e             exc_code,
    output logic [xlen-1:0]             exc_pc
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL,
        ST_DONE
    } state_e;

    state_e          state;
    logic [xlen-1:0] acc;
    logic [xlen-1:0] mcand;
    logic [xlen-1:0] mplier;
    logic [xlen-1:0] acc_nxt;
    logic [xlen-1:0] mplier_nxt;
    logic [4:0]      bit_cnt;

    assign rj_idx = bus.rj;
    assign rk_idx = bus.rk;
    assign ready  = state != ST_MUL;

    // one multiplier bit per cycle
    assign acc_nxt    = mplier[0] ? acc + mcand : acc;
    assign mplier_nxt = mplier >> 1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            wb_valid  <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            wb_valid  <= 1'b0;
            exc_valid <= 1'b0;
            if (state == ST_MUL) begin
                // stop early once no multiplier bits are left
                if (mplier_nxt == '0 || bit_cnt == 5'd31) begin
                    state    <= ST_DONE;
                    wb_valid <= 1'b1;
                end
            end else begin
                state <= ST_IDLE;
                if (bus.en) begin
                    if (bus.exc != issue_pkg::EXC_NONE) begin
                        exc_valid <= 1'b1;
                    end else if (bus.op == issue_pkg::OP_MUL) begin
                        state <= ST_MUL;
                    end else begin
                        wb_valid <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.en) begin
            acc      <= '0;
            mcand    <= rj_val;
            mplier   <= rk_val;
            bit_cnt  <= '0;
            wb_rd    <= bus.rd;
            wb_data  <= issue_pkg::alu_calc(bus.op, rj_val, rk_val, bus.imm);
            exc_code <= bus.exc;
            exc_pc   <= bus.pc;
        end else if (state == ST_MUL) begin
            acc     <= acc_nxt;
            mcand   <= mcand << 1;
            mplier  <= mplier_nxt;
            bit_cnt <= bit_cnt + 5'd1;
            wb_data <= acc_nxt;
        end
    end

    a_no_issue_busy: assert property (@(posedge clk) disable iff (!arst_n)
        bus.en |-> ready);

endmodule

/* commit_regfile.sv */
`timescale 1ns/1ps
// register file committing both writebacks in program order with forwarding to operand reads
module commit_regfile #(
    parameter int xlen = issue_pkg::XLEN
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        wb0_valid,
    input  logic [issue_pkg::REG_W-1:0] wb0_rd,
    input  logic [xlen-1:0]             wb0_data,
    input  logic                        wb1_valid,
    input  logic [issue_pkg::REG_W-1:0] wb1_rd,
    input  logic [xlen-1:0]             wb1_data,
    input  logic [issue_pkg::REG_W-1:0] rj0_idx,
    input  logic [issue_pkg::REG_W-1:0] rk0_idx,
    input  logic [issue_pkg::REG_W-1:0] rj1_idx,
    input  logic [issue_pkg::REG_W-1:0] rk1_idx,
    output logic [xlen-1:0]             rj0_val,
    output logic [xlen-1:0]             rk0_val,
    output logic [xlen-1:0]             rj1_val,
    output logic [xlen-1:0]             rk1_val
);

    // r0 has no storage and reads as zero
    logic [xlen-1:0] regs [1:31];

    // wb1 is younger so it wins over wb0
    function automatic logic [xlen-1:0] fwd_read(logic [issue_pkg::REG_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb1_valid && wb1_rd == idx) begin
            return wb1_data;
        end
        if (wb0_valid && wb0_rd == idx) begin
            return wb0_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rj0_val = fwd_read(rj0_idx);
        rk0_val = fwd_read(rk0_idx);
        rj1_val = fwd_read(rj1_idx);
        rk1_val = fwd_read(rk1_idx);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb0_valid && wb0_rd != '0) begin
                regs[wb0_rd] <= wb0_data;
            end
            // same rd in one cycle keeps the younger value
            if (wb1_valid && wb1_rd != '0) begin
                regs[wb1_rd] <= wb1_data;
            end
        end
    end

endmodule

/* issue_core_top.sv */
`timescale 1ns/1ps
// top level of the issue subsystem joining the issue buffer, both units and the register file
module issue_core_top #(
    parameter int xlen = issue_pkg::XLEN
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  issue_pkg::opcode_e          in0_op,
    input  logic [issue_pkg::REG_W-1:0] in0_rd,
    input  logic [issue_pkg::REG_W-1:0] in0_rj,
    input  logic [issue_pkg::REG_W-1:0] in0_rk,
    input  logic [xlen-1:0]             in0_imm,
    input  logic [xlen-1:0]             in0_pc,
    input  issue_pkg::exc_e             in0_exc,
    input  issue_pkg::opcode_e          in1_op,
    input  logic [issue_pkg::REG_W-1:0] in1_rd,
    input  logic [issue_pkg::REG_W-1:0] in1_rj,
    input  logic [issue_pkg::REG_W-1:0] in1_rk,
    input  logic [xlen-1:0]             in1_imm,
    input  logic [xlen-1:0]             in1_pc,
    input  issue_pkg::exc_e             in1_exc,
    output logic [1:0]                  num_read,
    output logic                        wb0_valid,
    output logic [issue_pkg::REG_W-1:0] wb0_rd,
    output logic [xlen-1:0]             wb0_data,
    output logic                        wb1_valid,
    output logic [issue_pkg::REG_W-1:0] wb1_rd,
    output logic [xlen-1:0]             wb1_data,
    output logic                        exc_valid,
    output issue_pkg::exc_e             exc_code,
    output logic [xlen-1:0]             exc_pc
);

    logic                        eu0_ready;
    logic [issue_pkg::REG_W-1:0] eu0_rj_idx;
    logic [issue_pkg::REG_W-1:0] eu0_rk_idx;
    logic [issue_pkg::REG_W-1:0] eu1_rj_idx;
    logic [issue_pkg::REG_W-1:0] eu1_rk_idx;
    logic [xlen-1:0]             eu0_rj_val;
    logic [xlen-1:0]             eu0_rk_val;
    logic [xlen-1:0]             eu1_rj_val;
    logic [xlen-1:0]             eu1_rk_val;

    uop_if #(.xlen(xlen)) eu0_bus ();
    uop_if #(.xlen(xlen)) eu1_bus ();

    issue_stage #(.xlen(xlen)) u_issue (
        .clk(clk), .arst_n(arst_n), .flush(flush),
        .in0_op(in0_op), .in0_rd(in0_rd), .in0_rj(in0_rj), .in0_rk(in0_rk),
        .in0_imm(in0_imm), .in0_pc(in0_pc), .in0_exc(in0_exc),
        .in1_op(in1_op), .in1_rd(in1_rd), .in1_rj(in1_rj), .in1_rk(in1_rk),
        .in1_imm(in1_imm), .in1_pc(in1_pc), .in1_exc(in1_exc),
        .num_read(num_read), .eu0_ready(eu0_ready),
        .eu0_bus(eu0_bus.issue), .eu1_bus(eu1_bus.issue)
    );

    mul_alu_unit #(.xlen(xlen)) u_eu0 (
        .clk(clk), .arst_n(arst_n), .bus(eu0_bus.exec),
        .rj_val(eu0_rj_val), .rk_val(eu0_rk_val),
        .wb_valid(wb0_valid), .wb_rd(wb0_rd), .wb_data(wb0_data),
        .rj_idx(eu0_rj_idx), .rk_idx(eu0_rk_idx), .ready(eu0_ready),
        .exc_valid(exc_valid), .exc_code(exc_code), .exc_pc(exc_pc)
    );

    alu_unit #(.xlen(xlen)) u_eu1 (
        .clk(clk), .arst_n(arst_n), .bus(eu1_bus.exec),
        .rj_val(eu1_rj_val), .rk_val(eu1_rk_val),
        .wb_valid(wb1_valid), .wb_rd(wb1_rd), .wb_data(wb1_data),
        .rj_idx(eu1_rj_idx), .rk_idx(eu1_rk_idx)
    );

    commit_regfile #(.xlen(xlen)) u_regfile (
        .clk(clk), .arst_n(arst_n),
        .wb0_valid(wb0_valid), .wb0_rd(wb0_rd), .wb0_data(wb0_data),
        .wb1_valid(wb1_valid), .wb1_rd(wb1_rd), .wb1_data(wb1_data),
        .rj0_idx(eu0_rj_idx), .rk0_idx(eu0_rk_idx),
        .rj1_idx(eu1_rj_idx), .rk1_idx(eu1_rk_idx),
        .rj0_val(eu0_rj_val), .rk0_val(eu0_rk_val),
        .rj1_val(eu1_rj_val), .rk1_val(eu1_rk_val)
    );

endmodule

/* issue_core_tb.sv */
`timescale 1ns/1ps
// testbench for issue_core_top, offers table rows in pairs and checks the writeback stream in order
module issue_core_tb;

    localparam int TIMEOUT = 1000;

    typedef struct {
        issue_pkg::opcode_e          op;
        logic [issue_pkg::REG_W-1:0] rd;
        logic [issue_pkg::REG_W-1:0] rj;
        logic [issue_pkg::REG_W-1:0] rk;
        logic [31:0]                 imm;
        logic [31:0]                 pc;
        issue_pkg::exc_e             exc;
    } row_t;

    // one expected result, either a register write or an exception report
    typedef struct {
        logic                        is_exc;
        logic [issue_pkg::REG_W-1:0] rd;
        logic [31:0]                 data;
        issue_pkg::exc_e             exc;
        logic [31:0]                 pc;
    } entry_t;

    // flush_at of zero means the group runs without a flush
    typedef struct {
        int first;
        int last;
        int flush_at;
        int discard_from;
    } group_t;

    logic                        clk;
    logic                        arst_n;
    logic                        flush;
    issue_pkg::opcode_e          in0_op;
    issue_pkg::opcode_e          in1_op;
    logic [issue_pkg::REG_W-1:0] in0_rd;
    logic [issue_pkg::REG_W-1:0] in0_rj;
    logic [issue_pkg::REG_W-1:0] in0_rk;
    logic [issue_pkg::REG_W-1:0] in1_rd;
    logic [issue_pkg::REG_W-1:0] in1_rj;
    logic [issue_pkg::REG_W-1:0] in1_rk;
    logic [31:0]                 in0_imm;
    logic [31:0]                 in0_pc;
    logic [31:0]                 in1_imm;
    logic [31:0]                 in1_pc;
    issue_pkg::exc_e             in0_exc;
    issue_pkg::exc_e             in1_exc;
    logic [1:0]                  num_read;
    logic                        wb0_valid;
    logic                        wb1_valid;
    logic [issue_pkg::REG_W-1:0] wb0_rd;
    logic [issue_pkg::REG_W-1:0] wb1_rd;
    logic [31:0]                 wb0_data;
    logic [31:0]                 wb1_data;
    logic                        exc_valid;
    issue_pkg::exc_e             exc_code;
    logic [31:0]                 exc_pc;

    row_t        rows[$];
    row_t        empty_row;
    group_t      groups[$];
    string       group_name[$];
    entry_t      exp_q[$];
    logic [31:0] model_regs [32];
    logic [31:0] lfsr_state = 32'd66;
    int          idx;
    int          err_count;
    int          tests_failed;

    issue_core_top #(.xlen(issue_pkg::XLEN)) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // galois form of x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return v;
    endfunction

    function automatic logic [31:0] ref_result(issue_pkg::opcode_e op, logic [31:0] a,
                                               logic [31:0] b, logic [31:0] imm);
        case (op)
            issue_pkg::OP_ADD:  return a + b;
            issue_pkg::OP_SUB:  return a - b;
            issue_pkg::OP_AND:  return a & b;
            issue_pkg::OP_OR:   return a | b;
            issue_pkg::OP_XOR:  return a ^ b;
            issue_pkg::OP_SLL:  return a << b[4:0];
            issue_pkg::OP_ADDI: return a + imm;
            issue_pkg::OP_MUL:  return a * b;
            default:            return '0;
        endcase
    endfunction

    task automatic add_row(issue_pkg::opcode_e op, int rd, int rj, int rk, logic [31:0] imm,
                           issue_pkg::exc_e exc);
        row_t r;
        r.op  = op;
        r.rd  = 5'(rd);
        r.rj  = 5'(rj);
        r.rk  = 5'(rk);
        r.imm = imm;
        r.pc  = 32'h1000 + 32'(rows.size() * 4);
        r.exc = exc;
        rows.push_back(r);
    endtask

    task automatic add_group(string name, int first, int flush_at, int discard_from);
        group_t g;
        g.first        = first;
        g.last         = rows.size();
        g.flush_at     = flush_at;
        g.discard_from = discard_from;
        groups.push_back(g);
        group_name.push_back(name);
    endtask

    task automatic build_table();
        int                 first;
        int                 rd;
        int                 rj;
        int                 rk;
        logic [2:0]         sel;
        logic [31:0]        imm;
        issue_pkg::opcode_e op;
        empty_row = '{op: issue_pkg::OP_NOP, rd: '0, rj: '0, rk: '0, imm: '0, pc: '0,
                      exc: issue_pkg::EXC_NONE};
        first = rows.size();
        add_row(issue_pkg::OP_ADDI, 1, 0, 0, 32'h15, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 2, 0, 0, 32'h7, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 3, 0, 0, 32'h1234_5678, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 4, 0, 0, 32'hF0F0_0FF0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADD, 5, 1, 2, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_SUB, 6, 3, 4, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_AND, 7, 3, 4, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_OR, 8, 1, 4, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_XOR, 9, 3, 1, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_SLL, 10, 1, 2, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 11, 3, 0, 32'hFFFF_FFFF, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_SLL, 12, 4, 1, 32'h0, issue_pkg::EXC_NONE);
        add_group("alu pairs", first, 0, 0);
        first = rows.size();
        add_row(issue_pkg::OP_ADD, 13, 1, 2, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADD, 14, 13, 1, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_SUB, 15, 14, 13, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 16, 0, 0, 32'h5, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 16, 0, 0, 32'h9, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADD, 17, 16, 16, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_XOR, 16, 17, 3, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_OR, 18, 16, 0, 32'h0, issue_pkg::EXC_NONE);
        add_group("hazards", first, 0, 0);
        first = rows.size();
        add_row(issue_pkg::OP_MUL, 19, 3, 4, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADD, 20, 19, 1, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 21, 0, 0, 32'h8000_0001, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_MUL, 22, 3, 21, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_XOR, 23, 22, 19, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_MUL, 24, 2, 0, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 25, 24, 0, 32'h3, issue_pkg::EXC_NONE);
        add_group("multiply", first, 0, 0);
        first = rows.size();
        add_row(issue_pkg::OP_NOP, 5, 1, 2, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADD, 26, 5, 6, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_NOP, 26, 0, 0, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_NOP, 0, 0, 0, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 27, 26, 0, 32'h1, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_NOP, 27, 0, 0, 32'h0, issue_pkg::EXC_NONE);
        add_group("nop rows", first, 0, 0);
        first = rows.size();
        add_row(issue_pkg::OP_ADD, 28, 1, 2, 32'h0, issue_pkg::EXC_INE);
        add_row(issue_pkg::OP_ADD, 29, 28, 1, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_NOP, 0, 0, 0, 32'h0, issue_pkg::EXC_SYS);
        add_row(issue_pkg::OP_ADDI, 28, 28, 0, 32'h4, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_MUL, 30, 3, 4, 32'h0, issue_pkg::EXC_INE);
        add_row(issue_pkg::OP_SUB, 31, 28, 2, 32'h0, issue_pkg::EXC_NONE);
        add_group("exceptions", first, 0, 0);
        // a long multiply holds the two rows behind it in the buffer until the flush
        first = rows.size();
        add_row(issue_pkg::OP_MUL, 1, 3, 21, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADD, 2, 1, 1, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 5, 0, 0, 32'h55, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADD, 6, 1, 5, 32'h0, issue_pkg::EXC_NONE);
        add_row(issue_pkg::OP_ADDI, 7, 2, 0, 32'h1, issue_pkg::EXC_NONE);
        add_group("flush", first, first + 3, first + 1);
        first = rows.size();
        for (int i = 0; i < 24; i++) begin
            sel = 3'(rand_bits(3));
            rd  = int'(rand_bits(5));
            rj  = int'(rand_bits(5));
            rk  = int'(rand_bits(5));
            imm = rand_bits(12);
            if (sel == 3'd7) begin
                op = issue_pkg::OP_MUL;
            end else begin
                op = issue_pkg::opcode_e'(4'(sel) + 4'd1);
            end
            add_row(op, rd, rj, rk, imm, issue_pkg::EXC_NONE);
        end
        add_group("random", first, 0, 0);
    endtask

    // in-order execution of one group, discarded rows left out
    task automatic run_model(group_t g);
        row_t   r;
        entry_t e;
        for (int i = g.first; i < g.last; i++) begin
            r = rows[i];
            if (i >= g.discard_from && i < g.flush_at) begin
                continue;
            end
            if (r.op == issue_pkg::OP_NOP && r.exc == issue_pkg::EXC_NONE) begin
                continue;
            end
            e.is_exc = r.exc != issue_pkg::EXC_NONE;
            e.rd     = r.rd;
            e.exc    = r.exc;
            e.pc     = r.pc;
            e.data   = ref_result(r.op, model_regs[r.rj], model_regs[r.rk], r.imm);
            if (!e.is_exc && r.rd != 5'd0) begin
                model_regs[r.rd] = e.data;
            end
            exp_q.push_back(e);
        end
    endtask

    task automatic report_mismatch(string what);
        $display("Mismatch at %0t ns: %s", $time, what);
        err_count++;
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        err_count++;
    endtask

    task automatic set_inputs(row_t a, row_t b);
        in0_op  = a.op;
        in0_rd  = a.rd;
        in0_rj  = a.rj;
        in0_rk  = a.rk;
        in0_imm = a.imm;
        in0_pc  = a.pc;
        in0_exc = a.exc;
        in1_op  = b.op;
        in1_rd  = b.rd;
        in1_rj  = b.rj;
        in1_rk  = b.rk;
        in1_imm = b.imm;
        in1_pc  = b.pc;
        in1_exc = b.exc;
    endtask

    task automatic check_write(string port, logic [4:0] rd, logic [31:0] data);
        entry_t e;
        if (exp_q.size() == 0) begin
            report_failure($sformatf("%s wrote r%0d at %0t ns with no result left to expect",
                                     port, rd, $time));
            return;
        end
        e = exp_q.pop_front();
        if (e.is_exc) begin
            report_mismatch($sformatf("%s wrote r%0d, expected exception at pc %h",
                                      port, rd, e.pc));
        end else if (rd !== e.rd) begin
            report_mismatch($sformatf("%s rd is %0d, expected %0d", port, rd, e.rd));
        end else if (data !== e.data) begin
            report_mismatch($sformatf("%s data for r%0d is %h, expected %h",
                                      port, rd, data, e.data));
        end
    endtask

    task automatic check_exception();
        entry_t e;
        if (exp_q.size() == 0) begin
            report_failure($sformatf("exception at pc %h reported at %0t ns when none was due",
                                     exc_pc, $time));
            return;
        end
        e = exp_q.pop_front();
        if (!e.is_exc) begin
            report_mismatch($sformatf("exception at pc %h, expected write of r%0d",
                                      exc_pc, e.rd));
        end else if (exc_code !== e.exc) begin
            report_mismatch($sformatf("exc_code is %0d, expected %0d", exc_code, e.exc));
        end else if (exc_pc !== e.pc) begin
            report_mismatch($sformatf("exc_pc is %h, expected %h", exc_pc, e.pc));
        end
    endtask

    // one clock, rows from idx up to lim are offered and num_read advances idx
    task automatic step(int lim, logic do_flush);
        row_t ra;
        row_t rb;
        int   adv;
        ra = empty_row;
        rb = empty_row;
        if (idx < lim) begin
            ra = rows[idx];
        end
        if (idx + 1 < lim) begin
            rb = rows[idx + 1];
        end
        @(posedge clk);
        #1;
        flush = do_flush;
        set_inputs(ra, rb);
        @(negedge clk);
        // unit 0 holds the older op of a pair
        if (wb0_valid) begin
            check_write("wb0", wb0_rd, wb0_data);
        end
        if (exc_valid) begin
            check_exception();
        end
        if (wb1_valid) begin
            check_write("wb1", wb1_rd, wb1_data);
        end
        if (num_read == 2'b10) begin
            report_mismatch("num_read shows the unused code 10");
        end
        adv = 0;
        if (num_read == 2'b11) begin
            adv = 2;
        end else if (num_read == 2'b01) begin
            adv = 1;
        end
        if (adv > lim - idx) begin
            adv = lim - idx;
        end
        idx = idx + adv;
    endtask

    task automatic run_group(int gi);
        group_t g;
        int     errs_before;
        int     waited;
        g = groups[gi];
        errs_before = err_count;
        exp_q.delete();
        run_model(g);
        idx = g.first;
        if (g.flush_at > 0) begin
            waited = 0;
            while (idx < g.flush_at && waited < TIMEOUT) begin
                step(g.flush_at, 1'b0);
                waited++;
            end
            if (idx < g.flush_at) begin
                report_failure("timeout before the rows up to the flush point were accepted");
            end
            step(g.flush_at, 1'b1);
        end
        waited = 0;
        while (idx < g.last && waited < TIMEOUT) begin
            step(g.last, 1'b0);
            waited++;
        end
        if (idx < g.last) begin
            report_failure($sformatf("timeout with rows from %0d never accepted", idx));
        end
        waited = 0;
        while (exp_q.size() > 0 && waited < TIMEOUT) begin
            step(g.last, 1'b0);
            waited++;
        end
        if (exp_q.size() > 0) begin
            report_failure($sformatf("timeout with %0d results never written back",
                                     exp_q.size()));
        end
        if (err_count == errs_before) begin
            $display("test %s passed", group_name[gi]);
        end else begin
            $display("test %s failed with %0d errors", group_name[gi], err_count - errs_before);
            tests_failed++;
        end
    endtask

    initial begin
        err_count    = 0;
        tests_failed = 0;
        idx          = 0;
        arst_n       = 1'b0;
        flush        = 1'b0;
        build_table();
        set_inputs(empty_row, empty_row);
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (int gi = 0; gi < groups.size(); gi++) begin
            run_group(gi);
        end
        // idle tail catches any stray writeback
        repeat (4) step(idx, 1'b0);
        $display("tests %0d, passed %0d, failed %0d, errors %0d", groups.size(),
                 groups.size() - tests_failed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* files.f */
issue_pkg.sv
uop_if.sv
issue_stage.sv
alu_unit.sv
mul_alu_unit.sv
commit_regfile.sv
issue_core_top.sv
issue_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module issue_core_tb -o issue_core_sim
./obj_dir/issue_core_sim | tee sim.log
if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
